// File: compile.f
+incdir+rtl
rtl/dma_pkg.sv
rtl/dma_wb_decode.sv
rtl/dma_request_table.sv
rtl/dma_transfer_engine.sv
rtl/dma_top.sv
verification/dma_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module dma_tb -f compile.f -o dma_sim \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/dma_sim > sim.log 2>&1 || true
cat sim.log

grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0

// File: verification/dma_tb.sv
// DMA request subsystem testbench

`timescale 1ns/1ps
`default_nettype none

`include "dma_defines.svh"

module dma_tb import dma_pkg::*; ();

  localparam int NUM_REQ      = 40;
  localparam int RESET_CYCLES = 8;
  // 200 cycles per request plus margin
  localparam int LIMIT_CYCLES = RESET_CYCLES + NUM_REQ * 200 + 1000;
  localparam int N            = `DMA_TABLE_ENTRIES;

  logic      clk;
  logic      reset_i;
  wb_addr_t  wb_addr_i;
  wb_data_t  wb_dat_i;
  logic      wb_we_i;
  logic      wb_cyc_i;
  logic      wb_stb_i;
  wb_data_t  wb_dat_o;
  logic      wb_ack_o;
  logic      xfer_valid_o;
  dma_ptr_t  xfer_entry_o;
  wb_addr_t  xfer_laddr_o;
  wb_addr_t  xfer_raddr_o;
  dma_tile_t xfer_rtile_o;
  logic      xfer_read_o;

  // Descriptor side of the model, stimulus process only
  logic      m_armed [0:N-1];
  wb_addr_t  m_laddr [0:N-1];
  wb_addr_t  m_raddr [0:N-1];
  dma_tile_t m_rtile [0:N-1];
  logic      m_read  [0:N-1];
  dma_size_t m_size  [0:N-1];
  int        m_seq   [0:N-1];
  int        arm_count;
  logic [31:0] rng_state;

  // Beat side of the model, monitor only
  int        seen_seq   [0:N-1];
  dma_size_t seen_beats [0:N-1];
  logic      active_valid;
  dma_ptr_t  active_entry;

  dma_top UUT (
    .clk          (clk),
    .reset_i      (reset_i),
    .wb_addr_i    (wb_addr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_we_i      (wb_we_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .xfer_valid_o (xfer_valid_o),
    .xfer_entry_o (xfer_entry_o),
    .xfer_laddr_o (xfer_laddr_o),
    .xfer_raddr_o (xfer_raddr_o),
    .xfer_rtile_o (xfer_rtile_o),
    .xfer_read_o  (xfer_read_o)
  );

  // 10 ns clock
  always begin
    clk = 1'b0;
    #5;
    clk = 1'b1;
    #5;
  end

  //////////////////////////////
  // Helpers

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic stop_on_error();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got == exp) else begin
      $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_condition(input logic cond, input string what);
    assert (cond) else begin
      $display("ERROR: %s", what);
      stop_on_error();
    end
  endtask

  // Words the model still expects for an armed entry
  function automatic dma_size_t words_left(input dma_ptr_t e);
    if (seen_seq[e] == m_seq[e]) begin
      return m_size[e] - seen_beats[e];
    end
    return m_size[e];
  endfunction

  function automatic logic any_armed();
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < N; i++) begin
      hit = hit | m_armed[i];
    end
    return hit;
  endfunction

  function automatic wb_addr_t bus_addr(input dma_ptr_t e, input logic [4:0] ofs);
    return {{(`DMA_ADDR_WIDTH-7){1'b0}}, e, ofs};
  endfunction

  //////////////////////////////
  // Wishbone tasks

  // One access cycle then one idle cycle, stb low while idle
  task automatic bus_write(input dma_ptr_t e, input logic [4:0] ofs, input wb_data_t data);
    @(posedge clk);
    #1;
    wb_addr_i = bus_addr(e, ofs);
    wb_dat_i  = data;
    wb_we_i   = 1'b1;
    wb_cyc_i  = 1'b1;
    wb_stb_i  = 1'b1;
    @(posedge clk);
    #1;
    wb_we_i   = 1'b0;
    wb_cyc_i  = rng_state[0];
    wb_stb_i  = 1'b0;
  endtask

  task automatic bus_read(input dma_ptr_t e, input logic [4:0] ofs, output wb_data_t data);
    @(posedge clk);
    #1;
    wb_addr_i = bus_addr(e, ofs);
    wb_we_i   = 1'b0;
    wb_cyc_i  = 1'b1;
    wb_stb_i  = 1'b1;
    // Read data settles well before the next edge
    #3;
    data = wb_dat_o;
    @(posedge clk);
    #1;
    wb_cyc_i  = rng_state[0];
    wb_stb_i  = 1'b0;
  endtask

  task automatic program_entry(input dma_ptr_t e);
    wb_data_t  laddr;
    wb_data_t  raddr;
    wb_data_t  tile_word;
    wb_data_t  dir_word;
    dma_size_t size;
    laddr     = next_rand() & 32'hFFFF_FFFC;
    raddr     = next_rand() & 32'hFFFF_FFFC;
    tile_word = next_rand();
    dir_word  = next_rand();
    size      = dma_size_t'(next_rand() % 32'd13);
    bus_write(e, `DMA_OFS_LADDR, laddr);
    bus_write(e, `DMA_OFS_SIZE, {16'd0, size});
    bus_write(e, `DMA_OFS_RTILE, tile_word);
    bus_write(e, `DMA_OFS_RADDR, raddr);
    bus_write(e, `DMA_OFS_DIR, dir_word);
    // Only the low bits of tile and direction are stored
    m_laddr[e] = laddr;
    m_raddr[e] = raddr;
    m_rtile[e] = tile_word[15:0];
    m_read[e]  = dir_word[0];
    m_size[e]  = size;
    arm_count  = arm_count + 1;
    m_seq[e]   = arm_count;
    m_armed[e] = 1'b1;
    bus_write(e, `DMA_OFS_STATUS, next_rand());
  endtask

  task automatic poll_status(input dma_ptr_t e);
    wb_data_t rd;
    bus_read(e, `DMA_OFS_STATUS, rd);
    if (!m_armed[e] || words_left(e) != '0) begin
      compare_value("wb_dat_o", rd, 32'h0);
    end else begin
      compare_value("wb_dat_o upper bits", {rd[31:1], 1'b0}, 32'h0);
      if (rd[0]) begin
        // Done read frees the entry
        m_armed[e] = 1'b0;
        bus_read(e, `DMA_OFS_STATUS, rd);
        compare_value("wb_dat_o", rd, 32'h0);
      end
    end
  endtask

  task automatic probe_zero_offset(input dma_ptr_t e, input logic [4:0] ofs_raw);
    logic [4:0] ofs;
    wb_data_t   rd;
    ofs = (ofs_raw == `DMA_OFS_STATUS) ? 5'h18 : ofs_raw;
    bus_read(e, ofs, rd);
    compare_value("wb_dat_o", rd, 32'h0);
  endtask

  //////////////////////////////
  // Beat monitor

  task automatic check_beat();
    dma_ptr_t e;
    wb_addr_t step;
    e = xfer_entry_o;
    check_condition(m_armed[e] && words_left(e) != '0,
                    "beat for an entry with no words outstanding");
    if (active_valid) begin
      compare_value("xfer_entry_o", 32'(e), 32'(active_entry));
    end else begin
      // New entry, no older lower entry may still wait
      for (int l = 0; l < N; l++) begin
        check_condition(!(l < int'(e) && m_armed[l] && seen_seq[l] != m_seq[l] &&
                          m_size[l] != '0 && m_seq[l] < m_seq[e]),
                        "entry started ahead of a lower pending entry");
      end
      seen_seq[e]   = m_seq[e];
      seen_beats[e] = '0;
      active_valid  = 1'b1;
      active_entry  = e;
    end
    step = wb_addr_t'(seen_beats[e]) << 2;
    compare_value("xfer_laddr_o", xfer_laddr_o, m_laddr[e] + step);
    compare_value("xfer_raddr_o", xfer_raddr_o, m_raddr[e] + step);
    compare_value("xfer_rtile_o", 32'(xfer_rtile_o), 32'(m_rtile[e]));
    compare_value("xfer_read_o", 32'(xfer_read_o), 32'(m_read[e]));
    seen_beats[e] = seen_beats[e] + 1'b1;
    if (words_left(e) == '0) begin
      active_valid = 1'b0;
    end
  endtask

  // Outputs stable at the falling edge
  always @(negedge clk) begin
    if (reset_i !== 1'b0) begin
      active_valid = 1'b0;
      active_entry = '0;
      for (int i = 0; i < N; i++) begin
        seen_seq[i]   = 0;
        seen_beats[i] = '0;
      end
    end else begin
      compare_value("wb_ack_o", 32'(wb_ack_o), 32'(wb_cyc_i & wb_stb_i));
      if (xfer_valid_o) begin
        check_beat();
      end else begin
        check_condition(!active_valid, "beat stream stopped before the last word of an entry");
      end
    end
  end

  //////////////////////////////
  // Stimulus

  initial begin
    dma_ptr_t    e;
    logic [31:0] r;
    logic        found;
    int          issued;
    reset_i   = 1'b1;
    wb_addr_i = '0;
    wb_dat_i  = '0;
    wb_we_i   = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    rng_state = 32'd39259;
    arm_count = 0;
    issued    = 0;
    for (int i = 0; i < N; i++) begin
      m_armed[i] = 1'b0;
      m_seq[i]   = 0;
      m_size[i]  = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_i = 1'b0;

    // Nothing armed, so reads give 0 and no beats appear
    for (int i = 0; i < N; i++) begin
      poll_status(dma_ptr_t'(i));
    end
    bus_write(2'd1, `DMA_OFS_SIZE, 32'd5);
    repeat (10) @(posedge clk);

    // Random programming interleaved with polls
    while (issued < NUM_REQ || any_armed()) begin
      r     = next_rand();
      found = 1'b0;
      e     = '0;
      for (int k = 0; k < N; k++) begin
        if (!found && !m_armed[(int'(r[5:4]) + k) % N]) begin
          found = 1'b1;
          e     = dma_ptr_t'((int'(r[5:4]) + k) % N);
        end
      end
      if (issued < NUM_REQ && found && r[1:0] != 2'd0) begin
        program_entry(e);
        issued = issued + 1;
      end else if (r[3:2] == 2'd0) begin
        probe_zero_offset(r[7:6], r[12:8]);
      end else begin
        poll_status(r[7:6]);
      end
    end

    repeat (10) @(posedge clk);
    $display("Test OK");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("Timeout: run did not complete within %0d cycles", LIMIT_CYCLES);
    stop_on_error();
  end

endmodule

`default_nettype wire

// File: rtl/dma_top.sv
// DMA request subsystem top level

`timescale 1ns/1ps
`default_nettype none

`include "dma_defines.svh"

module dma_top import dma_pkg::*; (
  input  wire logic     clk,
  input  wire logic     reset_i,

  // Wishbone slave
  input  wire wb_addr_t wb_addr_i,
  input  wire wb_data_t wb_dat_i,
  input  wire logic     wb_we_i,
  input  wire logic     wb_cyc_i,
  input  wire logic     wb_stb_i,
  output wb_data_t      wb_dat_o,
  output logic          wb_ack_o,

  // Beat stream
  output logic          xfer_valid_o,
  output dma_ptr_t      xfer_entry_o,
  output wb_addr_t      xfer_laddr_o,
  output wb_addr_t      xfer_raddr_o,
  output dma_tile_t     xfer_rtile_o,
  output logic          xfer_read_o
);

  // Decoder to table
  dma_req_t     if_write_req;
  dma_ptr_t     if_write_pos;
  dma_mask_t    if_write_select;
  logic         if_write_en;
  dma_ptr_t     if_valid_pos;
  logic         if_valid_set;
  logic         if_valid_en;
  logic         if_validrd_en;

  // Table to engine and back
  dma_req_t     req [0:`DMA_TABLE_ENTRIES-1];
  dma_entries_t valid;
  dma_entries_t done;
  logic         finish;
  dma_ptr_t     finish_pos;

  //////////////////////////////
  // Bus decode
  dma_wb_decode u_decode (
    .clk               (clk),
    .reset_i           (reset_i),
    .wb_addr_i         (wb_addr_i),
    .wb_dat_i          (wb_dat_i),
    .wb_we_i           (wb_we_i),
    .wb_cyc_i          (wb_cyc_i),
    .wb_stb_i          (wb_stb_i),
    .wb_dat_o          (wb_dat_o),
    .wb_ack_o          (wb_ack_o),
    .if_write_req_o    (if_write_req),
    .if_write_pos_o    (if_write_pos),
    .if_write_select_o (if_write_select),
    .if_write_en_o     (if_write_en),
    .if_valid_pos_o    (if_valid_pos),
    .if_valid_set_o    (if_valid_set),
    .if_valid_en_o     (if_valid_en),
    .if_validrd_en_o   (if_validrd_en),
    .done_i            (done)
  );

  // Descriptor table
  dma_request_table u_table (
    .clk               (clk),
    .reset_i           (reset_i),
    .if_write_req_i    (if_write_req),
    .if_write_pos_i    (if_write_pos),
    .if_write_select_i (if_write_select),
    .if_write_en_i     (if_write_en),
    .if_valid_pos_i    (if_valid_pos),
    .if_valid_set_i    (if_valid_set),
    .if_valid_en_i     (if_valid_en),
    .if_validrd_en_i   (if_validrd_en),
    .finish_i          (finish),
    .finish_pos_i      (finish_pos),
    .req_o             (req),
    .valid_o           (valid),
    .done_o            (done)
  );

  // Serial engine
  dma_transfer_engine u_engine (
    .clk          (clk),
    .reset_i      (reset_i),
    .req_i        (req),
    .valid_i      (valid),
    .done_i       (done),
    .finish_o     (finish),
    .finish_pos_o (finish_pos),
    .xfer_valid_o (xfer_valid_o),
    .xfer_entry_o (xfer_entry_o),
    .xfer_laddr_o (xfer_laddr_o),
    .xfer_raddr_o (xfer_raddr_o),
    .xfer_rtile_o (xfer_rtile_o),
    .xfer_read_o  (xfer_read_o)
  );

endmodule

`default_nettype wire

// File: rtl/dma_transfer_engine.sv
// DMA serial transfer engine

`timescale 1ns/1ps
`default_nettype none

`include "dma_defines.svh"

module dma_transfer_engine import dma_pkg::*; (
  input  wire logic         clk,
  input  wire logic         reset_i,

  input  wire dma_req_t     req_i [0:`DMA_TABLE_ENTRIES-1],
  input  wire dma_entries_t valid_i,
  input  wire dma_entries_t done_i,

  output logic              finish_o,
  output dma_ptr_t          finish_pos_o,

  // Beat strobe, no back-pressure
  output logic              xfer_valid_o,
  output dma_ptr_t          xfer_entry_o,
  output wb_addr_t          xfer_laddr_o,
  output wb_addr_t          xfer_raddr_o,
  output dma_tile_t         xfer_rtile_o,
  output logic              xfer_read_o
);

  dma_eng_state_t state_q;
  dma_eng_state_t state_d;

  dma_entries_t pending;
  logic         pick_found;
  dma_ptr_t     pick_ptr;
  dma_ptr_t     ptr_q;
  dma_req_t     sel_req;
  dma_size_t    sel_size;

  // Working copy of the active descriptor
  wb_addr_t     laddr_q;
  wb_addr_t     raddr_q;
  dma_tile_t    rtile_q;
  logic         read_q;
  dma_size_t    remain_q;

  //////////////////////////////
  // Lowest-index arbiter

  assign pending = valid_i & ~done_i;

  // Scan down so the lowest index wins
  always_comb begin
    pick_found = 1'b0;
    pick_ptr   = '0;
    for (int i = `DMA_TABLE_ENTRIES-1; i >= 0; i--) begin
      if (pending[i]) begin
        pick_found = 1'b1;
        pick_ptr   = dma_ptr_t'(i);
      end
    end
  end

  assign sel_req  = req_i[ptr_q];
  assign sel_size = sel_req[`DMA_REQFIELD_SIZE_LSB +: `DMA_REQFIELD_SIZE_WIDTH];

  //////////////////////////////
  // FSM

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (pick_found) state_d = LOAD;
      // Zero-length entry skips the beat phase
      LOAD:    state_d = (sel_size == '0) ? FINISH : XFER;
      XFER:    if (remain_q == dma_size_t'(1)) state_d = FINISH;
      FINISH:  state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q  <= IDLE;
      ptr_q    <= '0;
      remain_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && pick_found) begin
        ptr_q <= pick_ptr;
      end
      if (state_q == LOAD) begin
        remain_q <= sel_size;
      end else if (state_q == XFER) begin
        remain_q <= remain_q - dma_size_t'(1);
      end
    end
  end

  //////////////////////////////
  // Address datapath

  // Load on LOAD, step one word per beat
  always_ff @(posedge clk) begin
    if (state_q == LOAD) begin
      laddr_q <= sel_req[`DMA_REQFIELD_LADDR_LSB +: `DMA_REQFIELD_LADDR_WIDTH];
      raddr_q <= sel_req[`DMA_REQFIELD_RADDR_LSB +: `DMA_REQFIELD_RADDR_WIDTH];
      rtile_q <= sel_req[`DMA_REQFIELD_RTILE_LSB +: `DMA_REQFIELD_RTILE_WIDTH];
      read_q  <= sel_req[`DMA_REQFIELD_DIR_BIT];
    end else if (state_q == XFER) begin
      laddr_q <= laddr_q + wb_addr_t'(4);
      raddr_q <= raddr_q + wb_addr_t'(4);
    end
  end

  // Outputs
  assign xfer_valid_o = (state_q == XFER);
  assign xfer_entry_o = ptr_q;
  assign xfer_laddr_o = laddr_q;
  assign xfer_raddr_o = raddr_q;
  assign xfer_rtile_o = rtile_q;
  assign xfer_read_o  = read_q;

  // One-cycle completion pulse
  assign finish_o     = (state_q == FINISH);
  assign finish_pos_o = ptr_q;

endmodule

`default_nettype wire

// File: rtl/dma_request_table.sv
// DMA descriptor table

`timescale 1ns/1ps
`default_nettype none

`include "dma_defines.svh"

module dma_request_table import dma_pkg::*; (
  input  wire logic      clk,
  input  wire logic      reset_i,

  // Field write port
  input  wire dma_req_t  if_write_req_i,
  input  wire dma_ptr_t  if_write_pos_i,
  input  wire dma_mask_t if_write_select_i,
  input  wire logic      if_write_en_i,

  // Status port
  input  wire dma_ptr_t  if_valid_pos_i,
  input  wire logic      if_valid_set_i,
  input  wire logic      if_valid_en_i,
  input  wire logic      if_validrd_en_i,

  // Completion from the engine
  input  wire logic      finish_i,
  input  wire dma_ptr_t  finish_pos_i,

  output dma_req_t       req_o [0:`DMA_TABLE_ENTRIES-1],
  output dma_entries_t   valid_o,
  output dma_entries_t   done_o
);

  dma_req_t     req_q [0:`DMA_TABLE_ENTRIES-1];
  dma_entries_t valid_q;
  dma_entries_t done_q;
  // Bit mask of the fields picked by the select
  dma_req_t     wr_mask;

  //////////////////////////////
  // Select to bit mask

  always_comb begin
    wr_mask = '0;
    if (if_write_select_i[`DMA_REQMASK_LADDR]) begin
      wr_mask[`DMA_REQFIELD_LADDR_LSB +: `DMA_REQFIELD_LADDR_WIDTH] = '1;
    end
    if (if_write_select_i[`DMA_REQMASK_SIZE]) begin
      wr_mask[`DMA_REQFIELD_SIZE_LSB +: `DMA_REQFIELD_SIZE_WIDTH] = '1;
    end
    if (if_write_select_i[`DMA_REQMASK_RTILE]) begin
      wr_mask[`DMA_REQFIELD_RTILE_LSB +: `DMA_REQFIELD_RTILE_WIDTH] = '1;
    end
    if (if_write_select_i[`DMA_REQMASK_RADDR]) begin
      wr_mask[`DMA_REQFIELD_RADDR_LSB +: `DMA_REQFIELD_RADDR_WIDTH] = '1;
    end
    if (if_write_select_i[`DMA_REQMASK_DIR]) begin
      wr_mask[`DMA_REQFIELD_DIR_BIT] = 1'b1;
    end
  end

  //////////////////////////////
  // Descriptor storage

  // Untouched fields keep their value
  always_ff @(posedge clk) begin
    if (if_write_en_i) begin
      req_q[if_write_pos_i] <= (req_q[if_write_pos_i] & ~wr_mask) |
                               (if_write_req_i & wr_mask);
    end
  end

  //////////////////////////////
  // Valid and done bits

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= '0;
      done_q  <= '0;
    end else begin
      // Engine completion
      if (finish_i) begin
        done_q[finish_pos_i] <= 1'b1;
      end
      // Status write arms the entry
      if (if_valid_en_i && if_valid_set_i) begin
        valid_q[if_valid_pos_i] <= 1'b1;
        done_q[if_valid_pos_i]  <= 1'b0;
      end
      // Status read of a done entry frees it
      if (if_validrd_en_i && !if_valid_set_i) begin
        valid_q[if_valid_pos_i] <= 1'b0;
        done_q[if_valid_pos_i]  <= 1'b0;
      end
    end
  end

  assign req_o   = req_q;
  assign valid_o = valid_q;
  assign done_o  = done_q;

endmodule

`default_nettype wire

// File: rtl/dma_wb_decode.sv
// DMA Wishbone slave decode

`timescale 1ns/1ps
`default_nettype none

`include "dma_defines.svh"

module dma_wb_decode import dma_pkg::*; (
  input  wire logic      clk,
  input  wire logic      reset_i,

  input  wire wb_addr_t  wb_addr_i,
  input  wire wb_data_t  wb_dat_i,
  input  wire logic      wb_we_i,
  input  wire logic      wb_cyc_i,
  input  wire logic      wb_stb_i,
  output wb_data_t       wb_dat_o,
  output logic           wb_ack_o,

  output dma_req_t       if_write_req_o,
  output dma_ptr_t       if_write_pos_o,
  output dma_mask_t      if_write_select_o,
  output logic           if_write_en_o,

  output dma_ptr_t       if_valid_pos_o,
  output logic           if_valid_set_o,
  output logic           if_valid_en_o,
  output logic           if_validrd_en_o,

  input  wire dma_entries_t done_i
);

  logic [4:0]   ofs;
  dma_ptr_t     pos;
  logic         access;
  logic         field_hit;
  logic         status_wr;
  logic         status_rd;
  // Entries that got a status write and are not yet freed
  dma_entries_t armed_q;

  // Entry from bits 6:5, register from bits 4:0
  assign ofs    = wb_addr_i[4:0];
  assign pos    = wb_addr_i[`DMA_TABLE_PTRWIDTH+4:5];
  assign access = wb_cyc_i & wb_stb_i;

  // Classic cycle, ack in the same clock
  assign wb_ack_o = access;

  //////////////////////////////
  // Field writes

  // Same bus word copied into every field slot
  assign if_write_req_o = {wb_dat_i[`DMA_REQFIELD_LADDR_WIDTH-1:0],
                           wb_dat_i[`DMA_REQFIELD_SIZE_WIDTH-1:0],
                           wb_dat_i[`DMA_REQFIELD_RTILE_WIDTH-1:0],
                           wb_dat_i[`DMA_REQFIELD_RADDR_WIDTH-1:0],
                           wb_dat_i[0]};

  // One-hot select from the offset
  assign if_write_select_o[`DMA_REQMASK_LADDR] = (ofs == `DMA_OFS_LADDR);
  assign if_write_select_o[`DMA_REQMASK_SIZE]  = (ofs == `DMA_OFS_SIZE);
  assign if_write_select_o[`DMA_REQMASK_RTILE] = (ofs == `DMA_OFS_RTILE);
  assign if_write_select_o[`DMA_REQMASK_RADDR] = (ofs == `DMA_OFS_RADDR);
  assign if_write_select_o[`DMA_REQMASK_DIR]   = (ofs == `DMA_OFS_DIR);

  assign field_hit      = |if_write_select_o;
  assign if_write_pos_o = pos;
  assign if_write_en_o  = access & wb_we_i & field_hit;

  //////////////////////////////
  // Status register

  assign status_wr = access & wb_we_i & (ofs == `DMA_OFS_STATUS);
  assign status_rd = access & ~wb_we_i & (ofs == `DMA_OFS_STATUS);

  assign if_valid_pos_o  = pos;
  assign if_valid_en_o   = status_wr;
  // Read of a done entry frees it
  assign if_validrd_en_o = status_rd & armed_q[pos];
  // Entry stays valid unless this is a read that finds it done
  assign if_valid_set_o  = wb_we_i | ~done_i[pos];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      armed_q <= '0;
    end else if (status_wr) begin
      armed_q[pos] <= 1'b1;
    end else if (status_rd && done_i[pos]) begin
      armed_q[pos] <= 1'b0;
    end
  end

  // Done in bit 0, zero everywhere else
  always_comb begin
    wb_dat_o = '0;
    if (ofs == `DMA_OFS_STATUS) begin
      wb_dat_o[0] = done_i[pos];
    end
  end

endmodule

`default_nettype wire

// File: rtl/dma_pkg.sv
// DMA request subsystem types

`default_nettype none

package dma_pkg;

  `include "dma_defines.svh"

  //////////////////////////////
  // Bus vectors
  typedef logic [`DMA_ADDR_WIDTH-1:0] wb_addr_t;
  typedef logic [`DMA_DATA_WIDTH-1:0] wb_data_t;

  //////////////////////////////
  // Descriptor table vectors
  typedef logic [`DMA_TABLE_PTRWIDTH-1:0] dma_ptr_t;
  typedef logic [`DMA_REQMASK_WIDTH-1:0]  dma_mask_t;
  typedef logic [`DMA_REQUEST_WIDTH-1:0]  dma_req_t;
  typedef logic [`DMA_REQFIELD_SIZE_WIDTH-1:0]  dma_size_t;
  typedef logic [`DMA_REQFIELD_RTILE_WIDTH-1:0] dma_tile_t;
  // One bit per descriptor
  typedef logic [`DMA_TABLE_ENTRIES-1:0] dma_entries_t;

  // Transfer engine FSM
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    LOAD   = 2'd1,
    XFER   = 2'd2,
    FINISH = 2'd3
  } dma_eng_state_t;

endpackage

`default_nettype wire

// File: rtl/dma_defines.svh
// DMA request subsystem widths and register map

`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// Wishbone bus widths
`define DMA_ADDR_WIDTH 32
`define DMA_DATA_WIDTH 32

// Descriptor table size
`define DMA_TABLE_ENTRIES  4
`define DMA_TABLE_PTRWIDTH 2

// Descriptor fields, one select bit each
`define DMA_REQMASK_WIDTH 5
`define DMA_REQMASK_LADDR 0
`define DMA_REQMASK_SIZE  1
`define DMA_REQMASK_RTILE 2
`define DMA_REQMASK_RADDR 3
`define DMA_REQMASK_DIR   4

// Field widths
`define DMA_REQFIELD_LADDR_WIDTH 32
`define DMA_REQFIELD_SIZE_WIDTH  16
`define DMA_REQFIELD_RTILE_WIDTH 16
`define DMA_REQFIELD_RADDR_WIDTH 32
`define DMA_REQUEST_WIDTH        97

// Packed layout, laddr on top and direction in bit 0
`define DMA_REQFIELD_DIR_BIT   0
`define DMA_REQFIELD_RADDR_LSB 1
`define DMA_REQFIELD_RTILE_LSB 33
`define DMA_REQFIELD_SIZE_LSB  49
`define DMA_REQFIELD_LADDR_LSB 65

// Register offsets inside a 32-byte entry window
`define DMA_OFS_LADDR  5'h00
`define DMA_OFS_SIZE   5'h04
`define DMA_OFS_RTILE  5'h08
`define DMA_OFS_RADDR  5'h0C
`define DMA_OFS_DIR    5'h10
`define DMA_OFS_STATUS 5'h14

`endif
